/* sources.f */
branch_pkg.sv
branch_ifs.sv
branch_resolve.sv
btb_predictor.sv
redirect_ctrl.sv
branch_ctrl_top.sv
branch_ctrl_assertions.sv
tb_branch_ctrl.sv

/* Makefile */
# Verilator flow for the branch control testbench
# Pass or fail comes from the pass line in the simulation log

VERILATOR ?= verilator
TOP       ?= tb_branch_ctrl
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_branch_ctrl.sv */
//############################################################
// Testbench for the branch control top level.
// Directed and random stimulus; bound assertions check it.
//############################################################

`timescale 1ns/1ps

module tb_branch_ctrl;
	import branch_pkg::*;

	localparam addr_t PC_IDLE = 32'hffff_ff00;
	localparam addr_t PC_BYP  = 32'h3000_0010;
	localparam addr_t PC_P    = 32'h4000_0020;
	localparam addr_t IRQ_TO  = 32'h0000_0100;
	localparam int    MASK_TIMEOUT = 4;

	logic       clk, rst_n_i, stall_if_i, stall_mem_i, irq_jmp_i, load_bypass_i;
	addr_t      irq_jmp_to_i, jmp_num1_i, jmp_num2_i, pc_pred_i, pc_instr_i;
	data_t      data_rs1_i, data_rs2_i;
	jmp_kind_t  jmp_kind_i;
	logic       jmp_en_o, instr_mask_o;
	addr_t      jmp_to_o;
	hold_code_t hold_code_o;

	// Side inputs applied together with the next instruction
	logic  nxt_irq, nxt_stall_if, nxt_stall_mem, nxt_lb;
	addr_t nxt_pred;

	int    seed = 32'h1760_af85;
	int    tb_errors = 0;
	int    test_cnt = 0;
	int    mark = 0;
	data_t r1, r2;

	branch_ctrl_top dut_i (.*);

	always #20 clk = ~clk;

	function automatic int error_total();
		return tb_errors + dut_i.u_chk.err_cnt;
	endfunction

	task automatic drive(input jmp_kind_t kind, input data_t a, input data_t b,
		input addr_t n1, input addr_t n2, input addr_t pc);
		@(posedge clk);
		jmp_kind_i    <= kind;
		data_rs1_i    <= a;
		data_rs2_i    <= b;
		jmp_num1_i    <= n1;
		jmp_num2_i    <= n2;
		pc_instr_i    <= pc;
		pc_pred_i     <= nxt_pred;
		irq_jmp_i     <= nxt_irq;
		stall_if_i    <= nxt_stall_if;
		stall_mem_i   <= nxt_stall_mem;
		load_bypass_i <= nxt_lb;
		@(negedge clk);
	endtask

	task automatic idle();
		drive(JMP_NONE, '0, '0, '0, '0, PC_IDLE);
	endtask

	task automatic check_redirect(input logic en, input addr_t to);
		if (jmp_en_o !== en) begin
			$display("Fail t=%0t jmp_en_o got %b expected %b", $time, jmp_en_o, en);
			tb_errors++;
		end else if (en && (jmp_to_o !== to)) begin
			$display("Fail t=%0t jmp_to_o got %h expected %h", $time, jmp_to_o, to);
			tb_errors++;
		end
	endtask

	task automatic check_state(input logic mask, input hold_code_t code);
		if (instr_mask_o !== mask) begin
			$display("Fail t=%0t instr_mask_o got %b expected %b", $time, instr_mask_o, mask);
			tb_errors++;
		end
		if (hold_code_o !== code) begin
			$display("Fail t=%0t hold_code_o got %0d expected %0d", $time, hold_code_o, code);
			tb_errors++;
		end
	endtask

	task automatic wait_mask();
		int n;
		n = 0;
		idle();
		while (!instr_mask_o && (n < MASK_TIMEOUT)) begin
			@(negedge clk);
			n++;
		end
		if (!instr_mask_o) begin
			$display("Timeout: instr_mask_o did not rise after a misprediction");
			tb_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		test_cnt++;
		$display("Test %0d %s: %s", test_cnt, name, (error_total() == mark) ? "ok" : "errors");
		mark = error_total();
	endtask

	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		{stall_if_i, stall_mem_i, irq_jmp_i, load_bypass_i} = '0;
		{nxt_irq, nxt_stall_if, nxt_stall_mem, nxt_lb} = '0;
		irq_jmp_to_i = IRQ_TO;
		{jmp_num1_i, jmp_num2_i, pc_instr_i, data_rs1_i, data_rs2_i} = '0;
		pc_pred_i = PC_IDLE;
		nxt_pred = PC_IDLE;
		jmp_kind_i = JMP_NONE;
		repeat (10) @(posedge clk);
		rst_n_i <= 1'b1;

		// Every kind at fresh tags, equal operands every third time
		for (int i = 0; i < 28; i++) begin
			r1 = $random(seed);
			r2 = (i % 3 == 0) ? r1 : $random(seed);
			drive(jmp_kind_t'(3'(1 + i % 7)), r1, r2, $random(seed), $random(seed),
				32'h2000_0000 + i * 64);
		end
		drive(JMP_BLT, 32'hffff_ffff, 32'd1, 32'h100, 32'h20, 32'h2100_0000);
		check_redirect(1'b1, 32'h120);
		drive(JMP_BLTU, 32'hffff_ffff, 32'd1, 32'h100, 32'h20, 32'h2100_0040);
		check_redirect(1'b0, '0);
		finish_test("resolution");

		nxt_lb = 1'b1;
		drive(JMP_J, '0, '0, 32'h3000_0400, '0, PC_BYP);
		check_redirect(1'b0, '0);
		nxt_lb = 1'b0;
		nxt_pred = PC_BYP;
		idle();
		check_redirect(1'b0, '0);
		nxt_pred = PC_IDLE;
		finish_test("load bypass");

		drive(JMP_J, '0, '0, PC_P, 32'h200, PC_P);
		check_redirect(1'b1, PC_P + 32'h200);
		nxt_pred = PC_P;
		idle();
		check_redirect(1'b1, PC_P + 32'h200);
		nxt_pred = PC_IDLE;
		drive(JMP_BEQ, 32'd1, 32'd2, PC_P, 32'h300, PC_P);
		drive(JMP_BEQ, 32'd1, 32'd2, PC_P, 32'h300, PC_P);
		nxt_pred = PC_P;
		idle();
		check_redirect(1'b0, '0);
		nxt_pred = PC_IDLE;
		finish_test("learning");

		// Counter is strongly not taken here
		drive(JMP_BNE, 32'd1, 32'd2, PC_P, 32'h400, PC_P);
		check_redirect(1'b1, PC_P + 32'h400);
		wait_mask();
		drive(JMP_BNE, 32'd1, 32'd2, PC_P, 32'h400, PC_P);
		drive(JMP_BEQ, 32'd1, 32'd2, PC_P, 32'h400, PC_P);
		check_redirect(1'b1, PC_P + 32'd4);
		wait_mask();
		finish_test("misprediction");

		nxt_irq = 1'b1;
		drive(JMP_J, '0, '0, PC_P, 32'h500, PC_P);
		check_redirect(1'b1, IRQ_TO);
		nxt_pred = PC_P;
		idle();
		check_redirect(1'b1, IRQ_TO);
		nxt_irq = 1'b0;
		finish_test("interrupt");

		nxt_pred = PC_IDLE;
		nxt_stall_if = 1'b1;
		drive(JMP_BEQ, 32'd1, 32'd2, PC_P, '0, PC_P);
		check_redirect(1'b1, PC_P + 32'd4);
		check_state(1'b0, HOLD_EX);
		nxt_stall_if = 1'b0;
		nxt_stall_mem = 1'b1;
		drive(JMP_BEQ, 32'd1, 32'd2, PC_P, '0, PC_P);
		check_state(1'b0, HOLD_EX);
		nxt_stall_mem = 1'b0;
		nxt_pred = PC_P;
		idle();
		check_redirect(1'b1, PC_P + 32'h500);
		check_state(1'b0, HOLD_NONE);
		nxt_pred = PC_IDLE;
		idle();
		finish_test("hold");

		idle();
		$display("Tests: %0d, errors: %0d", test_cnt, error_total());
		if (error_total() == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* branch_ctrl_assertions.sv */
//############################################################
// Concurrent checks for the branch control top level.
// Bound into branch_ctrl_top; keeps a shadow target buffer.
//############################################################

`timescale 1ns/1ps

module branch_ctrl_assertions (
	input logic                   clk,
	input logic                   rst_n_i,
	input logic                   stall_if_i, stall_mem_i, irq_jmp_i, load_bypass_i,
	input branch_pkg::addr_t      irq_jmp_to_i, jmp_num1_i, jmp_num2_i,
	input branch_pkg::addr_t      pc_pred_i, pc_instr_i, jmp_to_o,
	input branch_pkg::data_t      data_rs1_i, data_rs2_i,
	input branch_pkg::jmp_kind_t  jmp_kind_i,
	input logic                   jmp_en_o, instr_mask_o,
	input branch_pkg::hold_code_t hold_code_o
);
	import branch_pkg::*;

	int err_cnt = 0;

	logic [BTB_ENTRIES-1:0] sh_valid;
	btb_tag_t               sh_tag    [BTB_ENTRIES];
	addr_t                  sh_target [BTB_ENTRIES];
	ctr_t                   sh_ctr    [BTB_ENTRIES];

	logic [3:0] f_idx, r_idx;
	logic       f_hit, r_hit, is_br, taken, hold, exp_mis, exp_en;
	logic       exp_mis_q;
	addr_t      target, exp_to;

	// Reference branch condition
	function automatic logic cond_met(input jmp_kind_t kind, input data_t a, input data_t b);
		case (kind)
			JMP_BEQ:  return a == b;
			JMP_BNE:  return a != b;
			JMP_BLT:  return $signed(a) < $signed(b);
			JMP_BGE:  return $signed(a) >= $signed(b);
			JMP_BLTU: return a < b;
			JMP_BGEU: return a >= b;
			JMP_J:    return 1'b1;
			default:  return 1'b0;
		endcase
	endfunction

	assign f_idx  = pc_pred_i[5:2];
	assign f_hit  = sh_valid[f_idx] && (sh_tag[f_idx] == pc_pred_i[31:6]);
	assign r_idx  = pc_instr_i[5:2];
	assign r_hit  = sh_valid[r_idx] && (sh_tag[r_idx] == pc_instr_i[31:6]);
	assign is_br  = (jmp_kind_i != JMP_NONE);
	assign taken  = !load_bypass_i && cond_met(jmp_kind_i, data_rs1_i, data_rs2_i);
	assign target = jmp_num1_i + jmp_num2_i;
	assign hold   = stall_if_i || stall_mem_i;

	assign exp_mis = is_br && (((r_hit && sh_ctr[r_idx][1]) != taken) ||
		(taken && r_hit && (sh_target[r_idx] != target)));

	// Interrupt first, then correction, then prediction
	always_comb begin
		exp_en = 1'b1;
		exp_to = irq_jmp_to_i;
		if (!irq_jmp_i && exp_mis) begin
			exp_to = taken ? target : pc_instr_i + 32'd4;
		end else if (!irq_jmp_i) begin
			exp_en = f_hit && sh_ctr[f_idx][1];
			exp_to = sh_target[f_idx];
		end
	end

	// Misprediction seen at the previous edge
	always_ff @(posedge clk) begin
		exp_mis_q <= exp_mis;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sh_valid <= '0;
		end else if (!hold && is_br) begin
			if (!r_hit && taken) begin
				sh_valid[r_idx]  <= 1'b1;
				sh_tag[r_idx]    <= pc_instr_i[31:6];
				sh_target[r_idx] <= target;
				sh_ctr[r_idx]    <= CTR_INIT_TAKEN;
			end else if (r_hit && taken) begin
				sh_target[r_idx] <= target;
				if (sh_ctr[r_idx] != 2'b11) begin
					sh_ctr[r_idx] <= sh_ctr[r_idx] + 2'd1;
				end
			end else if (r_hit && (sh_ctr[r_idx] != 2'b00)) begin
				sh_ctr[r_idx] <= sh_ctr[r_idx] - 2'd1;
			end
		end
	end

	a_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
		(jmp_en_o == exp_en) && (!exp_en || (jmp_to_o == exp_to)))
		else begin
			$error("Fail t=%0t jmp_en_o/jmp_to_o got %b/%h expected %b/%h",
				$time, $sampled(jmp_en_o), $sampled(jmp_to_o),
				$sampled(exp_en), $sampled(exp_to));
			err_cnt++;
		end

	a_hold_code: assert property (@(posedge clk) disable iff (!rst_n_i)
		hold_code_o == (hold ? HOLD_EX : HOLD_NONE))
		else begin
			$error("Fail t=%0t hold_code_o got %0d expected %0d", $time,
				$sampled(hold_code_o), $sampled(hold) ? HOLD_EX : HOLD_NONE);
			err_cnt++;
		end

	a_mask_update: assert property (@(posedge clk) disable iff (!rst_n_i)
		!hold |=> (instr_mask_o == exp_mis_q))
		else begin
			$error("Fail t=%0t instr_mask_o got %b expected %b", $time,
				$sampled(instr_mask_o), $sampled(exp_mis_q));
			err_cnt++;
		end

	a_mask_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		hold |=> $stable(instr_mask_o))
		else begin
			$error("instr_mask_o changed while the pipeline was held");
			err_cnt++;
		end

	a_mask_reset: assert property (@(posedge clk) !rst_n_i |-> !instr_mask_o)
		else begin
			$error("instr_mask_o is set during reset");
			err_cnt++;
		end

endmodule

bind branch_ctrl_top branch_ctrl_assertions u_chk (.*);

/* branch_ctrl_top.sv */
//############################################################
// Branch control top level for the five-stage pipeline.
// Connects resolver, target buffer and redirect unit.
//############################################################

`timescale 1ns/1ps

module branch_ctrl_top (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_if_i,
	input  logic                   stall_mem_i,
	input  logic                   irq_jmp_i,
	input  branch_pkg::addr_t      irq_jmp_to_i,
	input  branch_pkg::addr_t      jmp_num1_i,
	input  branch_pkg::addr_t      jmp_num2_i,
	input  branch_pkg::addr_t      pc_pred_i,
	input  branch_pkg::addr_t      pc_instr_i,
	input  branch_pkg::data_t      data_rs1_i,
	input  branch_pkg::data_t      data_rs2_i,
	input  branch_pkg::jmp_kind_t  jmp_kind_i,
	input  logic                   load_bypass_i,
	output logic                   jmp_en_o,
	output branch_pkg::addr_t      jmp_to_o,
	output logic                   instr_mask_o,
	output branch_pkg::hold_code_t hold_code_o
);
	import branch_pkg::*;

	logic  hold;
	logic  pred_taken;
	addr_t pred_target;
	logic  mispredict;

	resolve_if res ();

	branch_resolve u_resolve (
		.jmp_kind_i    (jmp_kind_i),
		.data_rs1_i    (data_rs1_i),
		.data_rs2_i    (data_rs2_i),
		.jmp_num1_i    (jmp_num1_i),
		.jmp_num2_i    (jmp_num2_i),
		.pc_instr_i    (pc_instr_i),
		.load_bypass_i (load_bypass_i),
		.res           (res.src)
	);

	btb_predictor u_btb (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.hold_i        (hold),
		.pc_pred_i     (pc_pred_i),
		.res           (res.btb),
		.pred_taken_o  (pred_taken),
		.pred_target_o (pred_target),
		.mispredict_o  (mispredict)
	);

	redirect_ctrl u_redirect (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.irq_jmp_i     (irq_jmp_i),
		.irq_jmp_to_i  (irq_jmp_to_i),
		.stall_if_i    (stall_if_i),
		.stall_mem_i   (stall_mem_i),
		.res           (res.redir),
		.pred_taken_i  (pred_taken),
		.pred_target_i (pred_target),
		.mispredict_i  (mispredict),
		.hold_o        (hold),
		.jmp_en_o      (jmp_en_o),
		.jmp_to_o      (jmp_to_o),
		.instr_mask_o  (instr_mask_o),
		.hold_code_o   (hold_code_o)
	);

endmodule

/* redirect_ctrl.sv */
//############################################################
// Fetch redirect by priority, hold code and mask register.
// Interrupt beats misprediction, which beats prediction.
//############################################################

`timescale 1ns/1ps

module redirect_ctrl (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   irq_jmp_i,
	input  branch_pkg::addr_t      irq_jmp_to_i,
	input  logic                   stall_if_i,
	input  logic                   stall_mem_i,
	resolve_if.redir               res,
	input  logic                   pred_taken_i,
	input  branch_pkg::addr_t      pred_target_i,
	input  logic                   mispredict_i,
	output logic                   hold_o,
	output logic                   jmp_en_o,
	output branch_pkg::addr_t      jmp_to_o,
	output logic                   instr_mask_o,
	output branch_pkg::hold_code_t hold_code_o
);
	import branch_pkg::*;

	addr_t fix_target;

	// Either stall freezes the execute stage
	assign hold_o      = stall_if_i || stall_mem_i;
	assign hold_code_o = hold_o ? HOLD_EX : HOLD_NONE;

	// Correct path after a wrong guess
	assign fix_target = res.taken ? res.target : (res.pc + PC_STEP);

	always_comb begin
		if (irq_jmp_i) begin
			jmp_en_o = 1'b1;
			jmp_to_o = irq_jmp_to_i;
		end else if (mispredict_i) begin
			jmp_en_o = 1'b1;
			jmp_to_o = fix_target;
		end else begin
			jmp_en_o = pred_taken_i;
			jmp_to_o = pred_target_i;
		end
	end

	// Masks the wrong-path instruction one cycle later
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			instr_mask_o <= 1'b0;
		end else if (!hold_o) begin
			instr_mask_o <= mispredict_i;
		end
	end

endmodule

/* btb_predictor.sv */
//############################################################
// Direct-mapped branch target buffer with 2-bit counters.
// Predicts at fetch, checks and learns at execute.
//############################################################

`timescale 1ns/1ps

module btb_predictor (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              hold_i,
	input  branch_pkg::addr_t pc_pred_i,
	resolve_if.btb            res,
	output logic              pred_taken_o,
	output branch_pkg::addr_t pred_target_o,
	output logic              mispredict_o
);
	import branch_pkg::*;

	logic [BTB_ENTRIES-1:0] valid_q;
	btb_tag_t               tag_q    [BTB_ENTRIES];
	addr_t                  target_q [BTB_ENTRIES];
	ctr_t                   ctr_q    [BTB_ENTRIES];

	btb_idx_t fetch_idx;
	btb_tag_t fetch_tag;
	logic     fetch_hit;

	btb_idx_t upd_idx;
	btb_tag_t upd_tag;
	logic     upd_hit;
	logic     upd_pred_taken;
	logic     target_diff;
	logic     upd_en;
	logic     alloc_en;

	// Fetch lookup
	assign fetch_idx = btb_index(pc_pred_i);
	assign fetch_tag = btb_tag(pc_pred_i);
	assign fetch_hit = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);

	// Counter upper bit gives the direction
	assign pred_taken_o  = fetch_hit && ctr_q[fetch_idx][1];
	assign pred_target_o = fetch_hit ? target_q[fetch_idx] : '0;

	// Second lookup at the resolved pc
	assign upd_idx = btb_index(res.pc);
	assign upd_tag = btb_tag(res.pc);
	assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

	assign upd_pred_taken = upd_hit && ctr_q[upd_idx][1];
	assign target_diff    = upd_hit && (target_q[upd_idx] != res.target);

	// Wrong direction, or right direction with a stale target
	assign mispredict_o = res.is_branch &&
		((upd_pred_taken != res.taken) || (res.taken && target_diff));

	assign upd_en = !hold_i && res.is_branch;

	// Only a taken miss earns an entry
	assign alloc_en = upd_en && !upd_hit && res.taken;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else if (alloc_en) begin
			valid_q[upd_idx] <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clk) begin
		if (alloc_en) begin
			tag_q[upd_idx]    <= upd_tag;
			target_q[upd_idx] <= res.target;
			ctr_q[upd_idx]    <= CTR_INIT_TAKEN;
		end else if (upd_en && upd_hit) begin
			ctr_q[upd_idx] <= ctr_next(ctr_q[upd_idx], res.taken);
			if (res.taken) begin
				target_q[upd_idx] <= res.target;
			end
		end
	end

endmodule

/* branch_resolve.sv */
//############################################################
// Execute-stage branch resolver.
// Decides taken by branch kind and computes the target.
//############################################################

`timescale 1ns/1ps

module branch_resolve (
	input  branch_pkg::jmp_kind_t jmp_kind_i,
	input  branch_pkg::data_t     data_rs1_i,
	input  branch_pkg::data_t     data_rs2_i,
	input  branch_pkg::addr_t     jmp_num1_i,
	input  branch_pkg::addr_t     jmp_num2_i,
	input  branch_pkg::addr_t     pc_instr_i,
	input  logic                  load_bypass_i,
	resolve_if.src                res
);
	import branch_pkg::*;

	logic rs1_lt_u;
	logic rs1_lt_s;
	logic taken_raw;

	assign rs1_lt_u = (data_rs1_i < data_rs2_i);

	// Differing sign bits decide directly
	assign rs1_lt_s = (data_rs1_i[DATA_W-1] == data_rs2_i[DATA_W-1]) ?
		rs1_lt_u : data_rs1_i[DATA_W-1];

	always_comb begin
		case (jmp_kind_i)
			JMP_BEQ: begin
				taken_raw = (data_rs1_i == data_rs2_i);
			end
			JMP_BNE: begin
				taken_raw = (data_rs1_i != data_rs2_i);
			end
			JMP_BLT: begin
				taken_raw = rs1_lt_s;
			end
			JMP_BGE: begin
				taken_raw = !rs1_lt_s;
			end
			JMP_BLTU: begin
				taken_raw = rs1_lt_u;
			end
			JMP_BGEU: begin
				taken_raw = !rs1_lt_u;
			end
			JMP_J: begin
				taken_raw = 1'b1;
			end
			default: begin
				taken_raw = 1'b0;
			end
		endcase
	end

	assign res.is_branch = (jmp_kind_i != JMP_NONE);

	// Operands still waiting on a load are not trusted
	assign res.taken = load_bypass_i ? 1'b0 : taken_raw;

	assign res.target = jmp_num1_i + jmp_num2_i;
	assign res.pc     = pc_instr_i;

endmodule

/* branch_ifs.sv */
//############################################################
// Resolved branch bus from the execute-stage resolver.
// Read by the target buffer and by the redirect unit.
//############################################################

`timescale 1ns/1ps

interface resolve_if;
	import branch_pkg::*;

	// Kind is not JMP_NONE
	logic  is_branch;
	logic  taken;
	addr_t target;
	// Address of the resolved instruction
	addr_t pc;

	modport src (
		output is_branch,
		output taken,
		output target,
		output pc
	);

	modport btb (
		input is_branch,
		input taken,
		input target,
		input pc
	);

	// Redirect only needs the correction address
	modport redir (
		input taken,
		input target,
		input pc
	);

endinterface

/* branch_pkg.sv */
//############################################################
// Shared types and sizes for the branch control block.
// Import into module bodies; use scoped names in port lists.
//############################################################

package branch_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Control-flow kind of the instruction in execute
	typedef enum logic [2:0] {
		JMP_NONE = 3'd0,
		JMP_BEQ  = 3'd1,
		JMP_BNE  = 3'd2,
		JMP_BLT  = 3'd3,
		JMP_BGE  = 3'd4,
		JMP_BLTU = 3'd5,
		JMP_BGEU = 3'd6,
		JMP_J    = 3'd7
	} jmp_kind_t;

	typedef enum logic [1:0] {
		HOLD_NONE = 2'b00,
		HOLD_EX   = 2'b01
	} hold_code_t;

	// Sequential fetch step
	localparam addr_t PC_STEP = 32'd4;

	// Branch target buffer geometry
	localparam int BTB_ENTRIES = 16;
	localparam int BTB_IDX_W   = 4;
	localparam int BTB_IDX_LSB = 2;
	localparam int BTB_TAG_LSB = BTB_IDX_LSB + BTB_IDX_W;

	typedef logic [BTB_IDX_W-1:0]          btb_idx_t;
	typedef logic [ADDR_W-BTB_TAG_LSB-1:0] btb_tag_t;
	typedef logic [1:0]                    ctr_t;

	localparam ctr_t CTR_MIN        = 2'b00;
	localparam ctr_t CTR_INIT_TAKEN = 2'b10;
	localparam ctr_t CTR_MAX        = 2'b11;

	function automatic btb_idx_t btb_index(input addr_t pc);
		return pc[BTB_TAG_LSB-1:BTB_IDX_LSB];
	endfunction

	function automatic btb_tag_t btb_tag(input addr_t pc);
		return pc[ADDR_W-1:BTB_TAG_LSB];
	endfunction

	// Saturating 2-bit counter step
	function automatic ctr_t ctr_next(input ctr_t ctr, input logic taken);
		ctr_t nxt;
		nxt = ctr;
		if (taken && (ctr != CTR_MAX)) begin
			nxt = ctr + 2'd1;
		end else if (!taken && (ctr != CTR_MIN)) begin
			nxt = ctr - 2'd1;
		end
		return nxt;
	endfunction

endpackage
